/* rtl/sim_platform_pkg.sv */
/* shared types, bus payload structs, address map and latency constants
   for the soft processor simulation platform */
package sim_platform_pkg;

    // ram geometry
    localparam int RAM_ADDR_W = 12;

    // plain vector types
    typedef logic [31:0]           data_t;
    typedef logic [31:0]           byte_addr_t;
    typedef logic [RAM_ADDR_W-1:0] word_addr_t;
    typedef logic [3:0]            strb_t;
    typedef logic [1:0]            resp_t;
    typedef logic [7:0]            uart_byte_t;

    // address map, ram spans 16 KB from base
    localparam byte_addr_t RAM_BASE  = 32'h0000_0000;
    localparam byte_addr_t UART_ADDR = 32'h0001_0000;

    // responder countdown length
    localparam int BUS_LATENCY = 5;
    localparam int LAT_CNT_W   = $clog2(BUS_LATENCY + 1);
    typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

    // uart byte counter, zero-extended on read
    localparam int UART_CNT_W = 16;
    typedef logic [UART_CNT_W-1:0] uart_cnt_t;

    // axi response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // write data channel payload
    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    // read data channel payload
    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

    // one access from slave to decoder
    typedef struct packed {
        byte_addr_t addr;
        data_t      wdata;
        strb_t      strb;
        logic       write;
    } mem_req_t;

    // decoder answer, one cycle after the request
    typedef struct packed {
        data_t rdata;
        logic  err;
    } mem_rsp_t;

endpackage

/* rtl/axil_latency_slave.sv */
/* axi4-lite slave with a fixed countdown before each access,
   one transaction in flight, writes win over reads */
`timescale 1ns/1ps

module axil_latency_slave (
    input  logic                         clk,
    input  logic                         rst,
    // write address
    input  sim_platform_pkg::byte_addr_t awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    // write data
    input  sim_platform_pkg::axil_w_t    wchan,
    input  logic                         wvalid,
    output logic                         wready,
    // write response
    output sim_platform_pkg::resp_t      bresp,
    output logic                         bvalid,
    input  logic                         bready,
    // read address
    input  sim_platform_pkg::byte_addr_t araddr,
    input  logic                         arvalid,
    output logic                         arready,
    // read data
    output sim_platform_pkg::axil_r_t    rchan,
    output logic                         rvalid,
    input  logic                         rready,
    // internal access path
    output sim_platform_pkg::mem_req_t   mem_req,
    output logic                         mem_req_valid,
    input  sim_platform_pkg::mem_rsp_t   mem_rsp
);
    import sim_platform_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        COUNT,
        ACCESS,
        WAIT_RSP,
        RESPOND
    } slave_state_t;

    slave_state_t state;
    lat_cnt_t     cnt;

    // per-channel taken flags
    logic aw_taken;
    logic w_taken;
    logic ar_taken;
    logic is_write;

    // latched request and response payload
    byte_addr_t aw_addr_q;
    byte_addr_t ar_addr_q;
    axil_w_t    w_q;
    data_t      rdata_q;
    resp_t      resp_q;

    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic start_wr;
    logic start_rd;
    logic rsp_done;

    // channels only open while idle and not yet holding a beat
    assign awready = (state == IDLE) && !aw_taken;
    assign wready  = (state == IDLE) && !w_taken;
    assign arready = (state == IDLE) && !ar_taken;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // start on the same edge the last needed beat lands
    assign start_wr = (state == IDLE) && (aw_taken || aw_fire) && (w_taken || w_fire);
    assign start_rd = (state == IDLE) && !start_wr && (ar_taken || ar_fire);

    assign rsp_done = is_write ? bready : rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            cnt      <= '0;
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
            ar_taken <= 1'b0;
            is_write <= 1'b0;
        end else begin
            // write beats consumed together
            if (start_wr) begin
                aw_taken <= 1'b0;
                w_taken  <= 1'b0;
            end else begin
                if (aw_fire)
                    aw_taken <= 1'b1;
                if (w_fire)
                    w_taken <= 1'b1;
            end

            if (start_rd)
                ar_taken <= 1'b0;
            else if (ar_fire)
                ar_taken <= 1'b1;

            case (state)
                IDLE: begin
                    if (start_wr || start_rd) begin
                        state    <= COUNT;
                        cnt      <= lat_cnt_t'(BUS_LATENCY);
                        is_write <= start_wr;
                    end
                end
                // BUS_LATENCY cycles here
                COUNT: begin
                    if (cnt == lat_cnt_t'(1))
                        state <= ACCESS;
                    else
                        cnt <= cnt - 1'b1;
                end
                ACCESS:   state <= WAIT_RSP;
                WAIT_RSP: state <= RESPOND;
                // hold until master takes it
                RESPOND: begin
                    if (rsp_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire)
            aw_addr_q <= awaddr;
        if (w_fire)
            w_q <= wchan;
        if (ar_fire)
            ar_addr_q <= araddr;
        // decoder answer is valid during wait_rsp
        if (state == WAIT_RSP) begin
            rdata_q <= mem_rsp.rdata;
            resp_q  <= mem_rsp.err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // single access cycle
    assign mem_req_valid = (state == ACCESS);

    always_comb begin
        mem_req.addr  = is_write ? aw_addr_q : ar_addr_q;
        mem_req.wdata = w_q.data;
        mem_req.strb  = is_write ? w_q.strb : '0;
        mem_req.write = is_write;
    end

    assign bvalid     = (state == RESPOND) && is_write;
    assign rvalid     = (state == RESPOND) && !is_write;
    assign bresp      = resp_q;
    assign rchan.data = rdata_q;
    assign rchan.resp = resp_q;

endmodule

/* rtl/byte_en_bram.sv */
/* true dual-port block ram, read-only port a for fetch,
   byte-enable read/write port b for the bus */
`timescale 1ns/1ps

module byte_en_bram (
    input  logic                         clk,
    // fetch port
    input  logic                         en_a,
    input  sim_platform_pkg::word_addr_t addr_a,
    output sim_platform_pkg::data_t      data_out_a,
    // data port
    input  logic                         en_b,
    input  sim_platform_pkg::word_addr_t addr_b,
    input  sim_platform_pkg::strb_t      be_b,
    input  sim_platform_pkg::data_t      data_in_b,
    output sim_platform_pkg::data_t      data_out_b
);
    import sim_platform_pkg::*;

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    data_t mem [DEPTH];

    // clean contents at time zero in simulation
    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;
    end

    // port a, registered read
    always_ff @(posedge clk) begin
        if (en_a)
            data_out_a <= mem[addr_a];
    end

    // port b, old word out while enabled bytes update
    always_ff @(posedge clk) begin
        if (en_b) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (be_b[b])
                    mem[addr_b][b*8 +: 8] <= data_in_b[b*8 +: 8];
            end
            data_out_b <= mem[addr_b];
        end
    end

endmodule

/* rtl/mmio_decode.sv */
/* address decode for ram and uart capture, uart byte counter
   and slave-error responses for unmapped accesses */
`timescale 1ns/1ps

module mmio_decode (
    input  logic                         clk,
    input  logic                         rst,
    // request from slave
    input  sim_platform_pkg::mem_req_t   mem_req,
    input  logic                         mem_req_valid,
    output sim_platform_pkg::mem_rsp_t   mem_rsp,
    // ram port b
    output logic                         en_b,
    output sim_platform_pkg::word_addr_t addr_b,
    output sim_platform_pkg::strb_t      be_b,
    output sim_platform_pkg::data_t      data_in_b,
    input  sim_platform_pkg::data_t      data_out_b,
    // uart capture
    output logic                         uart_valid,
    output sim_platform_pkg::uart_byte_t uart_byte
);
    import sim_platform_pkg::*;

    typedef enum logic [1:0] {
        SEL_ZERO,
        SEL_RAM,
        SEL_COUNT
    } rsp_sel_t;

    logic      ram_hit;
    logic      uart_hit;
    logic      uart_wr;
    rsp_sel_t  sel_q;
    logic      err_q;
    uart_cnt_t uart_count;

    // ram hit when upper bits match base
    assign ram_hit  = mem_req.addr[31:RAM_ADDR_W+2] == RAM_BASE[31:RAM_ADDR_W+2];
    assign uart_hit = mem_req.addr == UART_ADDR;
    // only low byte lane carries the character
    assign uart_wr  = mem_req_valid && uart_hit && mem_req.write && mem_req.strb[0];

    // port b follows the request directly, zero enables on reads
    assign en_b      = mem_req_valid && ram_hit;
    assign addr_b    = mem_req.addr[RAM_ADDR_W+1:2];
    assign be_b      = mem_req.write ? mem_req.strb : '0;
    assign data_in_b = mem_req.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q      <= SEL_ZERO;
            err_q      <= 1'b0;
            uart_valid <= 1'b0;
            uart_count <= '0;
        end else begin
            // pick the source for next cycle's response
            if (mem_req_valid && ram_hit)
                sel_q <= SEL_RAM;
            else if (mem_req_valid && uart_hit && !mem_req.write)
                sel_q <= SEL_COUNT;
            else
                sel_q <= SEL_ZERO;
            err_q      <= mem_req_valid && !ram_hit && !uart_hit;
            uart_valid <= uart_wr;
            if (uart_wr)
                uart_count <= uart_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (uart_wr)
            uart_byte <= mem_req.wdata[7:0];
    end

    always_comb begin
        case (sel_q)
            SEL_RAM:   mem_rsp.rdata = data_out_b;
            SEL_COUNT: mem_rsp.rdata = data_t'(uart_count);
            default:   mem_rsp.rdata = '0;
        endcase
        mem_rsp.err = err_q;
    end

endmodule

/* rtl/sim_platform_top.sv */
/* platform top, axi4-lite latency slave, address decoder and
   shared block ram with a fetch port */
`timescale 1ns/1ps

module sim_platform_top (
    input  logic                         clk,
    input  logic                         rst,
    // axi4-lite slave
    input  sim_platform_pkg::byte_addr_t awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  sim_platform_pkg::axil_w_t    wchan,
    input  logic                         wvalid,
    output logic                         wready,
    output sim_platform_pkg::resp_t      bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  sim_platform_pkg::byte_addr_t araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output sim_platform_pkg::axil_r_t    rchan,
    output logic                         rvalid,
    input  logic                         rready,
    // instruction fetch
    input  logic                         ifetch_en,
    input  sim_platform_pkg::word_addr_t ifetch_addr,
    output sim_platform_pkg::data_t      ifetch_data,
    // uart capture
    output logic                         uart_valid,
    output sim_platform_pkg::uart_byte_t uart_byte
);
    import sim_platform_pkg::*;

    mem_req_t   mem_req;
    logic       mem_req_valid;
    mem_rsp_t   mem_rsp;
    logic       en_b;
    word_addr_t addr_b;
    strb_t      be_b;
    data_t      data_in_b;
    data_t      data_out_b;

    axil_latency_slave u_slave (
        .clk, .rst,
        .awaddr, .awvalid, .awready,
        .wchan, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rchan, .rvalid, .rready,
        .mem_req, .mem_req_valid, .mem_rsp
    );

    mmio_decode u_decode (
        .clk, .rst,
        .mem_req, .mem_req_valid, .mem_rsp,
        .en_b, .addr_b, .be_b, .data_in_b, .data_out_b,
        .uart_valid, .uart_byte
    );

    // fetch on port a, bus on port b
    byte_en_bram u_ram (
        .clk,
        .en_a       (ifetch_en),
        .addr_a     (ifetch_addr),
        .data_out_a (ifetch_data),
        .en_b, .addr_b, .be_b, .data_in_b, .data_out_b
    );

endmodule

/* dv/sim_platform_tb.sv */
/* testbench for the platform top, file-driven bus and fetch stimulus,
   lfsr back-pressure, uart monitor and typed compare tasks */
`timescale 1ns/1ps

module sim_platform_tb;
    import sim_platform_pkg::*;

    logic       clk = 1'b0;
    logic       rst;
    byte_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_w_t    wchan;
    logic       wvalid;
    logic       wready;
    resp_t      bresp;
    logic       bvalid;
    logic       bready;
    byte_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_r_t    rchan;
    logic       rvalid;
    logic       rready;
    logic       ifetch_en;
    word_addr_t ifetch_addr;
    data_t      ifetch_data;
    logic       uart_valid;
    uart_byte_t uart_byte;

    // galois lfsr state for back-pressure and aw/w gaps
    logic [31:0] lfsr_q = 32'he72c1c9c;
    // characters seen on the uart pulse
    uart_byte_t  uart_seen[$];

    sim_platform_top u_dut (.*);

    // 40 ns period
    always #20 clk = ~clk;

    // pulse sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (!rst && uart_valid)
            uart_seen.push_back(uart_byte);
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // x^32 + x^22 + x^2 + x + 1, right shifting
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | 32'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_data(input string tname, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("FAILED %s: data expected %h actual %h", tname, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string tname, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            $display("FAILED %s: resp expected %h actual %h", tname, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input string tname, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            $display("FAILED %s: uart byte expected %h actual %h", tname, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string tname, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %b actual %b", tname, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string tname, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s: response latency expected %0d actual %0d",
                     tname, exp, act);
            abort_run();
        end
    endtask

    function automatic logic handshake_level(input string sig);
        if (sig == "awready")
            return awready;
        else if (sig == "wready")
            return wready;
        else if (sig == "arready")
            return arready;
        else if (sig == "bvalid")
            return bvalid;
        else if (sig == "rvalid")
            return rvalid;
        return 1'bx;
    endfunction

    // entered and left on a falling edge
    task automatic wait_level(input string sig, input logic level, input string tname);
        int n;
        n = 0;
        while (handshake_level(sig) !== level) begin
            @(negedge clk);
            n++;
            if (n >= 64) begin
                $display("timeout in %s: %s never reached %b", tname, sig, level);
                abort_run();
            end
        end
    endtask

    // entered on the falling edge after the last request beat was taken
    task automatic wait_response(input string sig, input string tname);
        int n;
        n = 0;
        while (handshake_level(sig) !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n >= 64) begin
                $display("timeout in %s: %s never reached 1", tname, sig);
                abort_run();
            end
        end
        // countdown, access cycle, then the returning response
        check_cycles(tname, BUS_LATENCY + 2, n);
    endtask

    task automatic bus_write(input string tname, input byte_addr_t addr, input data_t data,
                             input strb_t strb, input resp_t exp_resp);
        int unsigned order;
        int unsigned gap;
        int unsigned hold;
        resp_t       held;
        draw_bits(1, order);
        draw_bits(3, gap);
        draw_bits(3, hold);
        fork
            begin
                // aw late when order set
                if (order == 1)
                    repeat (gap) @(negedge clk);
                awaddr  = addr;
                awvalid = 1'b1;
                wait_level("awready", 1'b1, tname);
                @(negedge clk);
                awvalid = 1'b0;
            end
            begin
                if (order == 0)
                    repeat (gap) @(negedge clk);
                wchan.data = data;
                wchan.strb = strb;
                wvalid     = 1'b1;
                wait_level("wready", 1'b1, tname);
                @(negedge clk);
                wvalid = 1'b0;
            end
        join
        wait_response("bvalid", tname);
        held = bresp;
        // stalled response, nothing new taken
        repeat (hold) begin
            check_bit(tname, "bvalid held", 1'b1, bvalid);
            check_resp(tname, held, bresp);
            check_bit(tname, "awready in stall", 1'b0, awready);
            check_bit(tname, "arready in stall", 1'b0, arready);
            @(negedge clk);
        end
        check_resp(tname, exp_resp, bresp);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_bit(tname, "awready after b", 1'b1, awready);
        check_bit(tname, "wready after b", 1'b1, wready);
        check_bit(tname, "arready after b", 1'b1, arready);
    endtask

    task automatic bus_read(input string tname, input byte_addr_t addr, input data_t exp_data,
                            input resp_t exp_resp);
        int unsigned hold;
        axil_r_t     held;
        draw_bits(3, hold);
        araddr  = addr;
        arvalid = 1'b1;
        wait_level("arready", 1'b1, tname);
        @(negedge clk);
        arvalid = 1'b0;
        wait_response("rvalid", tname);
        held = rchan;
        repeat (hold) begin
            check_bit(tname, "rvalid held", 1'b1, rvalid);
            check_data(tname, held.data, rchan.data);
            check_resp(tname, held.resp, rchan.resp);
            check_bit(tname, "awready in stall", 1'b0, awready);
            check_bit(tname, "arready in stall", 1'b0, arready);
            @(negedge clk);
        end
        check_data(tname, exp_data, rchan.data);
        check_resp(tname, exp_resp, rchan.resp);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_bit(tname, "arready after r", 1'b1, arready);
        check_bit(tname, "awready after r", 1'b1, awready);
    endtask

    // data due one cycle after the enable
    task automatic fetch_word(input string tname, input word_addr_t word, input data_t exp);
        ifetch_addr = word;
        ifetch_en   = 1'b1;
        @(negedge clk);
        ifetch_en = 1'b0;
        check_data(tname, exp, ifetch_data);
    endtask

    task automatic expect_uart(input string tname, input logic present, input uart_byte_t exp);
        int n;
        n = 0;
        if (!present) begin
            if (uart_seen.size() != 0) begin
                $display("%s: uart pulse seen where none was expected", tname);
                abort_run();
            end
        end else begin
            // rising edges keep clear of the monitor
            while (uart_seen.size() == 0) begin
                @(posedge clk);
                n++;
                if (n >= 64) begin
                    $display("timeout in %s: uart_valid never pulsed", tname);
                    abort_run();
                end
            end
            @(negedge clk);
            check_byte(tname, exp, uart_seen.pop_front());
        end
    endtask

    initial begin
        int              fd;
        int              n;
        int              ntests;
        string           line;
        string           tname;
        logic [7:0]      cmd;
        logic [8*32-1:0] tname_raw;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [3:0]      strb;
        logic [31:0]     exp_data;
        logic [1:0]      exp_resp;

        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wchan       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        ifetch_en   = 1'b0;
        ifetch_addr = '0;
        ntests      = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        check_bit("reset", "awready", 1'b1, awready);
        check_bit("reset", "wready", 1'b1, wready);
        check_bit("reset", "arready", 1'b1, arready);
        check_bit("reset", "bvalid", 1'b0, bvalid);
        check_bit("reset", "rvalid", 1'b0, rvalid);
        check_bit("reset", "uart_valid", 1'b0, uart_valid);

        fd = $fopen("dv/sim_platform_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/sim_platform_input.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            // comments and blank lines
            if (line.len() == 0 || line.substr(0, 0) == "#")
                continue;
            n = $sscanf(line, "%s %s %h %h %h %h %h",
                        cmd, tname_raw, addr, data, strb, exp_data, exp_resp);
            // whitespace-only lines
            if (n <= 0)
                continue;
            if (n != 7) begin
                $display("malformed stimulus line: %s", line);
                abort_run();
            end
            tname = $sformatf("%0s", tname_raw);
            ntests++;
            case (cmd)
                "W": bus_write(tname, addr, data, strb, exp_resp);
                "R": bus_read(tname, addr, exp_data, exp_resp);
                "F": begin
                    if (strb == 4'h0) begin
                        fetch_word(tname, word_addr_t'(addr), exp_data);
                    end else begin
                        // fetch while a bus read of the same word counts down
                        fork
                            bus_read(tname, byte_addr_t'({word_addr_t'(addr), 2'b00}),
                                     exp_data, exp_resp);
                            begin
                                wait_level("arready", 1'b0, tname);
                                fetch_word(tname, word_addr_t'(addr), exp_data);
                            end
                        join
                    end
                end
                "U": expect_uart(tname, strb[0], exp_data[7:0]);
                default: begin
                    $display("unknown command in line: %s", line);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);

        if (ntests == 0) begin
            $display("no test lines were read from the stimulus file");
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* dv/sim_platform_input.txt */
# cmd name addr data strb exp_data exp_resp, all numbers hex
# W write, R read, F fetch (addr is word index, strb 1 adds a bus read), U uart (strb 1 byte, 0 none)
W be_full0    00000010 11223344 f 00000000 0
W be_full1    00000014 aabbccdd f 00000000 0
W be_lo       00000010 000000ee 1 00000000 0
W be_hi       00000010 99000000 8 00000000 0
W be_mid      00000014 00555500 6 00000000 0
W be_zero     00000014 ffffffff 0 00000000 0
R rd_merge0   00000010 00000000 0 992233ee 0
R rd_merge1   00000014 00000000 0 aa5555dd 0
W top_word    00003ffc cafef00d f 00000000 0
F fetch_w4    00000004 00000000 0 992233ee 0
F fetch_busy  00000005 00000000 1 aa5555dd 0
F fetch_top   00000fff 00000000 1 cafef00d 0
W uart_h      00010000 00000048 1 00000000 0
U uart_h_chk  00000000 00000000 1 00000048 0
W uart_i      00010000 12345669 f 00000000 0
U uart_i_chk  00000000 00000000 1 00000069 0
W uart_nolane 00010000 00000021 e 00000000 0
U uart_none   00000000 00000000 0 00000000 0
R uart_count  00010000 00000000 0 00000002 0
W bad_wr      00020000 deadbeef f 00000000 2
R bad_rd      00020000 00000000 0 00000000 2
W bad_wr_hi   00004000 0badf00d f 00000000 2
R bad_rd_hi   00004000 00000000 0 00000000 2
W bad_uart    00010004 00000041 1 00000000 2
U bad_none    00000000 00000000 0 00000000 0
R no_side0    00000000 00000000 0 00000000 0
R no_side_cnt 00010000 00000000 0 00000002 0
F fetch_w0    00000000 00000000 0 00000000 0

/* sim_platform_top.f */
rtl/sim_platform_pkg.sv
rtl/axil_latency_slave.sv
rtl/byte_en_bram.sv
rtl/mmio_decode.sv
rtl/sim_platform_top.sv
dv/sim_platform_tb.sv

/* Makefile */
# Verilator build and run for the simulation platform testbench

VERILATOR ?= verilator
TOP       ?= sim_platform_tb
FILELIST  ?= sim_platform_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_ARGS  ?=

.PHONY: sim clean

# a failing run ends in $$fatal, so the binary exits non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
